// File: project.f
+incdir+hw
hw/tag_store_pkg.sv
hw/tag_ctrl.sv
hw/tag_way.sv
hw/way_select.sv
hw/tag_store_top.sv
sim/tag_store_sva.sv
sim/tag_store_tb.sv

// File: sim/tag_store_tb.sv
// Directed testbench of the tag store; run as the simulation top with the project file list
`include "tag_store_defines.svh"
`timescale 1ns/10ps

module tag_store_tb import tag_store_pkg::*;;

  localparam int num_sets = 1 << `TS_INDEX_W;
  localparam int num_ways = `TS_NUM_WAYS;
  // Six tests of at most a few dozen requests, with ample margin
  localparam int watchdog_cycles = 2000;

  logic      clk_i = 1'b0;
  logic      rst_n_i;
  logic      req_valid_i;
  logic      req_ready_o;
  op_e       req_op_i;
  index_t    req_index_i;
  tag_t      req_tag_i;
  logic      req_dirty_i;
  way_mask_t req_way_mask_i;
  logic      res_valid_o;
  logic      res_ready_i;
  logic      res_hit_o;
  way_mask_t res_way_o;
  logic      res_evict_o;
  tag_t      res_evict_tag_o;

  // Reference contents of every set and the round-robin pointer
  bit   m_valid [num_sets][num_ways];
  bit   m_dirty [num_sets][num_ways];
  tag_t m_tag   [num_sets][num_ways];
  int   m_ptr;

  int errors;
  int tests;
  // Response as seen in its first cycle
  logic      got_hit;
  way_mask_t got_way;
  logic      got_evict;
  tag_t      got_etag;

  tag_store_top i_tag_store_top (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_op_i        (req_op_i),
    .req_index_i     (req_index_i),
    .req_tag_i       (req_tag_i),
    .req_dirty_i     (req_dirty_i),
    .req_way_mask_i  (req_way_mask_i),
    .res_valid_o     (res_valid_o),
    .res_ready_i     (res_ready_i),
    .res_hit_o       (res_hit_o),
    .res_way_o       (res_way_o),
    .res_evict_o     (res_evict_o),
    .res_evict_tag_o (res_evict_tag_o)
  );

  always #4 clk_i = ~clk_i;

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s: got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Predicts one response and applies its write to the model
  task automatic predict(input op_e op, input index_t idx, input tag_t tag, input logic dirty,
                         input way_mask_t mask, output logic hit, output way_mask_t way,
                         output logic evict, output tag_t etag);
    int hw;
    int vw;
    int c;
    hit = 1'b0;
    way = '0;
    evict = 1'b0;
    etag = '0;
    hw = -1;
    vw = -1;
    if (op == OP_FLUSH) begin
      way = mask;
      for (int w = 0; w < num_ways; w++) begin
        if (mask[w]) begin
          evict = m_valid[idx][w] && m_dirty[idx][w];
          etag = evict ? m_tag[idx][w] : '0;
          m_valid[idx][w] = 1'b0;
          m_dirty[idx][w] = 1'b0;
          m_tag[idx][w] = '0;
        end
      end
    end else begin
      for (int w = 0; w < num_ways; w++) begin
        if (mask[w] && m_valid[idx][w] && m_tag[idx][w] == tag) hw = w;
      end
      if (hw >= 0) begin
        hit = 1'b1;
        way = way_mask_t'(1) << hw;
        if (dirty) m_dirty[idx][hw] = 1'b1;
      end else begin
        // Lowest free enabled way first
        for (int w = 0; w < num_ways; w++) begin
          if (vw < 0 && mask[w] && !m_valid[idx][w]) vw = w;
        end
        if (vw < 0) begin
          for (int k = 0; k < num_ways; k++) begin
            c = (m_ptr + k) % num_ways;
            if (vw < 0 && mask[c]) vw = c;
          end
          if (vw >= 0) m_ptr = (vw + 1) % num_ways;
        end
        if (vw >= 0) begin
          way = way_mask_t'(1) << vw;
          evict = m_valid[idx][vw] && m_dirty[idx][vw];
          etag = evict ? m_tag[idx][vw] : '0;
          m_valid[idx][vw] = 1'b1;
          m_dirty[idx][vw] = dirty;
          m_tag[idx][vw] = tag;
        end
      end
    end
  endtask

  // One full request and response, with a random stall of up to gap_max cycles
  task automatic run_req(input op_e op, input index_t idx, input tag_t tag, input logic dirty,
                         input way_mask_t mask, input int gap_max);
    logic      e_hit;
    way_mask_t e_way;
    logic      e_evict;
    tag_t      e_etag;
    int        gap;
    predict(op, idx, tag, dirty, mask, e_hit, e_way, e_evict, e_etag);
    gap = $urandom % (gap_max + 1);
    @(posedge clk_i);
    req_valid_i    <= 1'b1;
    req_op_i       <= op;
    req_index_i    <= idx;
    req_tag_i      <= tag;
    req_dirty_i    <= dirty;
    req_way_mask_i <= mask;
    do @(negedge clk_i); while (!req_ready_o);
    // Accept edge
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    @(negedge clk_i);
    if (res_valid_o !== 1'b1) begin
      $display("Response valid missing one cycle after accept at %0t", $time);
      errors++;
    end
    got_hit = res_hit_o;
    got_way = res_way_o;
    got_evict = res_evict_o;
    got_etag = res_evict_tag_o;
    expect_eq("res_hit_o", got_hit, e_hit);
    expect_eq("res_way_o", got_way, e_way);
    expect_eq("res_evict_o", got_evict, e_evict);
    expect_eq("res_evict_tag_o", got_etag, e_etag);
    repeat (gap) begin
      @(negedge clk_i);
      if (res_valid_o !== 1'b1 || req_ready_o !== 1'b0 ||
          {res_hit_o, res_way_o, res_evict_o, res_evict_tag_o} !==
          {got_hit, got_way, got_evict, got_etag}) begin
        $display("Response or handshake moved while stalled at %0t", $time);
        errors++;
      end
    end
    @(posedge clk_i);
    res_ready_i <= 1'b1;
    // Transfer edge
    @(posedge clk_i);
    res_ready_i <= 1'b0;
    @(negedge clk_i);
    if (res_valid_o !== 1'b0 || req_ready_o !== 1'b1) begin
      $display("Handshake did not return to idle after the transfer at %0t", $time);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests++;
    $display("[TEST] %s: %0d errors", name, errors - err_start);
  endtask

  task automatic reset_then_miss(input tag_t tag);
    int e0;
    e0 = errors;
    @(negedge clk_i);
    expect_eq("req_ready_o", req_ready_o, 1'b1);
    expect_eq("res_valid_o", res_valid_o, 1'b0);
    run_req(OP_LOOKUP, 4'd3, tag, 1'b0, 4'hF, 0);
    expect_eq("res_way_o first miss", got_way, 4'b0001);
    finish_test("reset_miss", e0);
  endtask

  task automatic repeat_lookup_hit(input tag_t tag);
    int e0;
    e0 = errors;
    run_req(OP_LOOKUP, 4'd3, tag, 1'b0, 4'hF, 1);
    expect_eq("res_hit_o repeat", got_hit, 1'b1);
    finish_test("hit", e0);
  endtask

  task automatic dirty_flush_evict(input tag_t tag);
    int e0;
    e0 = errors;
    run_req(OP_LOOKUP, 4'd3, tag, 1'b1, 4'hF, 1);
    run_req(OP_FLUSH, 4'd3, '0, 1'b0, 4'b0001, 1);
    expect_eq("res_evict_o flush", got_evict, 1'b1);
    expect_eq("res_evict_tag_o flush", got_etag, tag);
    run_req(OP_LOOKUP, 4'd3, tag, 1'b0, 4'hF, 1);
    expect_eq("res_hit_o after flush", got_hit, 1'b0);
    finish_test("dirty_upgrade", e0);
  endtask

  task automatic victim_round_robin();
    int   e0;
    tag_t base;
    e0 = errors;
    base = tag_t'($urandom);
    // Odd ways dirty, so evictions alternate
    for (int i = 0; i < num_ways; i++) begin
      run_req(OP_LOOKUP, 4'd5, tag_t'(base + i), i[0], 4'hF, 1);
    end
    for (int i = 0; i < num_ways; i++) begin
      run_req(OP_LOOKUP, 4'd5, tag_t'(base + 4 + i), 1'b0, 4'hF, 1);
    end
    finish_test("victim", e0);
  endtask

  task automatic masked_fill_clean_flush();
    int   e0;
    tag_t base;
    e0 = errors;
    base = tag_t'($urandom);
    for (int i = 0; i < 3; i++) begin
      run_req(OP_LOOKUP, 4'd7, tag_t'(base + i), 1'b0, 4'b1100, 1);
      expect_eq("res_way_o outside mask", got_way & 4'b0011, 4'b0000);
    end
    run_req(OP_FLUSH, 4'd7, '0, 1'b0, 4'b0100, 1);
    expect_eq("res_evict_o clean flush", got_evict, 1'b0);
    finish_test("mask_flush", e0);
  endtask

  task automatic stalled_responses();
    int        e0;
    op_e       op;
    way_mask_t mask;
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      op = (i % 3 == 2) ? OP_FLUSH : OP_LOOKUP;
      mask = (op == OP_FLUSH) ? way_mask_t'(1) << ($urandom % num_ways) : 4'hF;
      run_req(op, index_t'($urandom), tag_t'($urandom), 1'($urandom), mask, 5);
    end
    finish_test("backpressure", e0);
  endtask

  initial begin
    #(watchdog_cycles * 8);
    $display("Watchdog expired, the DUT stopped responding");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    tag_t t0;
    void'($urandom(68));
    errors = 0;
    tests = 0;
    m_ptr = 0;
    rst_n_i = 1'b0;
    req_valid_i = 1'b0;
    req_op_i = OP_LOOKUP;
    req_index_i = '0;
    req_tag_i = '0;
    req_dirty_i = 1'b0;
    req_way_mask_i = '0;
    res_ready_i = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    t0 = tag_t'($urandom);
    reset_then_miss(t0);
    repeat_lookup_hit(t0);
    dirty_flush_evict(t0);
    victim_round_robin();
    masked_fill_clean_flush();
    stalled_responses();
    // Bound checker failures count as errors
    if (i_tag_store_top.i_tag_store_sva.fail_count != 0) begin
      $display("Bound assertions failed %0d times",
               i_tag_store_top.i_tag_store_sva.fail_count);
      errors += i_tag_store_top.i_tag_store_sva.fail_count;
    end
    $display("Summary: %0d tests, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: sim/tag_store_sva.sv
// Handshake and way indicator assertions for the tag store, bound into the top level
`timescale 1ns/10ps

module tag_store_sva import tag_store_pkg::*; (
  input logic      clk_i,
  input logic      rst_n_i,
  input logic      req_valid_i,
  input logic      req_ready_o,
  input logic      res_valid_o,
  input logic      res_ready_i,
  input logic      res_hit_o,
  input way_mask_t res_way_o,
  input logic      res_evict_o,
  input tag_t      res_evict_tag_o
);

  // Failed assertion count, read by the testbench
  int unsigned fail_count = 0;

  // A stalled response keeps valid and every field until it is taken
  a_res_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_o && !res_ready_i |=> res_valid_o &&
    $stable({res_hit_o, res_way_o, res_evict_o, res_evict_tag_o}))
    else begin
      fail_count++;
      $error("Response changed while stalled");
    end

  // At most one way named in a response
  a_way_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_o |-> $onehot0(res_way_o))
    else begin
      fail_count++;
      $error("Response way is not one-hot");
    end

  // One request in flight, answered on the next edge
  a_no_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i && req_ready_o |=> res_valid_o && !req_ready_o)
    else begin
      fail_count++;
      $error("Accepted request not answered on the next edge with ready low");
    end

endmodule

bind tag_store_top tag_store_sva i_tag_store_sva (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .req_valid_i     (req_valid_i),
  .req_ready_o     (req_ready_o),
  .res_valid_o     (res_valid_o),
  .res_ready_i     (res_ready_i),
  .res_hit_o       (res_hit_o),
  .res_way_o       (res_way_o),
  .res_evict_o     (res_evict_o),
  .res_evict_tag_o (res_evict_tag_o)
);

// File: hw/tag_store_top.sv
// Top level of the cache tag store; controller, one tag_way per way and the way selector
`include "tag_store_defines.svh"
`timescale 1ns/10ps

module tag_store_top import tag_store_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Request port
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  op_e       req_op_i,
  input  index_t    req_index_i,
  input  tag_t      req_tag_i,
  input  logic      req_dirty_i,
  input  way_mask_t req_way_mask_i,
  // Response port
  output logic      res_valid_o,
  input  logic      res_ready_i,
  output logic      res_hit_o,
  output way_mask_t res_way_o,
  output logic      res_evict_o,
  output tag_t      res_evict_tag_o
);

  // Registered request
  op_e       op_q;
  tag_t      tag_q;
  logic      dirty_q;
  way_mask_t mask_q;
  logic      res_fire;

  // Shared array controls
  way_mask_t ram_rd;
  way_mask_t ram_we;
  index_t    ram_index;
  line_t     ram_wdata;

  // Way results
  line_t [`TS_NUM_WAYS-1:0] lines;
  way_mask_t                match;

  // Write-back decision
  way_mask_t sel_way;
  logic      wr_en;
  line_t     wr_line;

  tag_ctrl i_tag_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (req_valid_i),
    .req_op_i       (req_op_i),
    .req_index_i    (req_index_i),
    .req_tag_i      (req_tag_i),
    .req_dirty_i    (req_dirty_i),
    .req_way_mask_i (req_way_mask_i),
    .req_ready_o    (req_ready_o),
    .res_valid_o    (res_valid_o),
    .res_ready_i    (res_ready_i),
    .res_fire_o     (res_fire),
    .op_q_o         (op_q),
    .tag_q_o        (tag_q),
    .dirty_q_o      (dirty_q),
    .mask_q_o       (mask_q),
    .sel_way_i      (sel_way),
    .wr_en_i        (wr_en),
    .wr_line_i      (wr_line),
    .ram_rd_o       (ram_rd),
    .ram_we_o       (ram_we),
    .ram_index_o    (ram_index),
    .ram_wdata_o    (ram_wdata)
  );

  // Identical ways, each compares against the held request tag
  for (genvar w = 0; w < `TS_NUM_WAYS; w++) begin : gen_ways
    tag_way i_tag_way (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .rd_i      (ram_rd[w]),
      .we_i      (ram_we[w]),
      .index_i   (ram_index),
      .wdata_i   (ram_wdata),
      .cmp_tag_i (tag_q),
      .line_o    (lines[w]),
      .match_o   (match[w])
    );
  end

  way_select i_way_select (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .op_i            (op_q),
    .dirty_i         (dirty_q),
    .mask_i          (mask_q),
    .lines_i         (lines),
    .match_i         (match),
    .res_fire_i      (res_fire),
    .sel_way_o       (sel_way),
    .wr_en_o         (wr_en),
    .wr_line_o       (wr_line),
    .res_hit_o       (res_hit_o),
    .res_way_o       (res_way_o),
    .res_evict_o     (res_evict_o),
    .res_evict_tag_o (res_evict_tag_o)
  );

endmodule

// File: hw/way_select.sv
// Merges the way read results; picks hit or victim way, forms the response and the write-back line
`include "tag_store_defines.svh"
`timescale 1ns/10ps

module way_select import tag_store_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  op_e                        op_i,
  input  logic                       dirty_i,
  input  way_mask_t                  mask_i,
  input  line_t [`TS_NUM_WAYS-1:0]   lines_i,
  input  way_mask_t                  match_i,
  input  logic                       res_fire_i,
  output way_mask_t                  sel_way_o,
  output logic                       wr_en_o,
  output line_t                      wr_line_o,
  output logic                       res_hit_o,
  output way_mask_t                  res_way_o,
  output logic                       res_evict_o,
  output tag_t                       res_evict_tag_o
);

  way_mask_t valid_way;
  way_mask_t hit_way;
  way_mask_t free_way;
  way_mask_t victim_way;
  way_idx_t  ptr_q;
  way_idx_t  free_idx;
  way_idx_t  rr_idx;
  way_idx_t  victim_idx;
  logic      is_lookup;
  logic      hit;
  logic      use_rr;
  line_t     sel_line;

  always_comb begin
    for (int w = 0; w < `TS_NUM_WAYS; w++) begin
      valid_way[w] = lines_i[w].valid;
    end
  end

  assign is_lookup = (op_i == OP_LOOKUP);
  assign hit_way   = match_i & mask_i;
  assign hit       = is_lookup & (|hit_way);

  // Invalid ways among the enabled ones
  assign free_way = mask_i & ~valid_way;
  assign use_rr   = ~(|free_way);

  // Lowest free way wins
  always_comb begin
    free_idx = '0;
    for (int w = `TS_NUM_WAYS - 1; w >= 0; w--) begin
      if (free_way[w]) begin
        free_idx = way_idx_t'(w);
      end
    end
  end

  // First enabled way at or above the pointer, wrapping around
  always_comb begin : proc_rr
    way_idx_t cand;
    rr_idx = ptr_q;
    for (int k = `TS_NUM_WAYS - 1; k >= 0; k--) begin
      cand = ptr_q + way_idx_t'(k);
      if (mask_i[cand]) begin
        rr_idx = cand;
      end
    end
  end

  assign victim_idx = use_rr ? rr_idx : free_idx;
  // No victim at all with an empty mask
  assign victim_way = (|mask_i) ? (way_mask_t'(1) << victim_idx) : '0;

  // Flush names its way, lookup takes the hit or else the victim
  always_comb begin
    if (!is_lookup) begin
      sel_way_o = mask_i;
    end else if (hit) begin
      sel_way_o = hit_way;
    end else begin
      sel_way_o = victim_way;
    end
  end

  // Stored line of the selected way, one-hot OR mux
  always_comb begin
    sel_line = '0;
    for (int w = 0; w < `TS_NUM_WAYS; w++) begin
      if (sel_way_o[w]) begin
        sel_line = sel_line | lines_i[w];
      end
    end
  end

  always_comb begin
    wr_en_o   = 1'b0;
    wr_line_o = '0;
    if (!is_lookup) begin
      // Flush clears the way
      wr_en_o = 1'b1;
    end else if (hit) begin
      // Only a clean line needs the dirty upgrade
      wr_en_o   = dirty_i & ~sel_line.dirty;
      wr_line_o = line_t'{valid: 1'b1, dirty: 1'b1, tag: sel_line.tag};
    end else begin
      // Refill, tag comes from the controller
      wr_en_o         = |mask_i;
      wr_line_o.valid = 1'b1;
      wr_line_o.dirty = dirty_i;
    end
  end

  // Pointer moves past the victim only when it made the choice
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (res_fire_i && is_lookup && !hit && use_rr && (|mask_i)) begin
      ptr_q <= victim_idx + 2'd1;
    end
  end

  assign res_hit_o       = hit;
  assign res_way_o       = sel_way_o;
  // Hits never evict; miss and flush evict a valid dirty line
  assign res_evict_o     = ~hit & sel_line.valid & sel_line.dirty;
  assign res_evict_tag_o = res_evict_o ? sel_line.tag : '0;

endmodule

// File: hw/tag_way.sv
// One way of the tag store; tag and dirty array per set, valid flops, registered read and compare
`include "tag_store_defines.svh"
`timescale 1ns/10ps

module tag_way import tag_store_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   rd_i,
  input  logic   we_i,
  input  index_t index_i,
  input  line_t  wdata_i,
  input  tag_t   cmp_tag_i,
  output line_t  line_o,
  output logic   match_o
);

  localparam int unsigned num_sets = 1 << `TS_INDEX_W;

  // Valid bits must be known after reset
  logic [num_sets-1:0] valid_q;

  // Tag and dirty storage, one entry per set
  tag_t tag_mem   [num_sets];
  logic dirty_mem [num_sets];

  // Read register, holds until the next read
  line_t line_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (we_i) begin
      valid_q[index_i] <= wdata_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      tag_mem[index_i]   <= wdata_i.tag;
      dirty_mem[index_i] <= wdata_i.dirty;
    end
  end

  // An invalid entry reads back as an all-zero line
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      line_q <= '0;
    end else if (rd_i) begin
      line_q <= valid_q[index_i] ?
                line_t'{valid: 1'b1, dirty: dirty_mem[index_i], tag: tag_mem[index_i]} :
                line_t'('0);
    end
  end

  assign line_o = line_q;

  // Hit in this way
  assign match_o = line_q.valid & (line_q.tag == cmp_tag_i);

endmodule

// File: hw/tag_ctrl.sv
// Request register and idle/respond FSM of the tag store; drives the shared way array controls
`include "tag_store_defines.svh"
`timescale 1ns/10ps

module tag_ctrl import tag_store_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Request port
  input  logic      req_valid_i,
  input  op_e       req_op_i,
  input  index_t    req_index_i,
  input  tag_t      req_tag_i,
  input  logic      req_dirty_i,
  input  way_mask_t req_way_mask_i,
  output logic      req_ready_o,
  // Response handshake
  output logic      res_valid_o,
  input  logic      res_ready_i,
  output logic      res_fire_o,
  // Registered request towards the ways and the selector
  output op_e       op_q_o,
  output tag_t      tag_q_o,
  output logic      dirty_q_o,
  output way_mask_t mask_q_o,
  // Write-back decision from the selector
  input  way_mask_t sel_way_i,
  input  logic      wr_en_i,
  input  line_t     wr_line_i,
  // Array controls, broadcast to all ways
  output way_mask_t ram_rd_o,
  output way_mask_t ram_we_o,
  output index_t    ram_index_o,
  output line_t     ram_wdata_o
);

  state_e    state_q;
  state_e    state_d;
  logic      accept;

  // Captured request
  op_e       op_q;
  logic      dirty_q;
  way_mask_t mask_q;
  tag_t      tag_q;
  index_t    index_q;

  // Ready only while nothing is outstanding
  assign req_ready_o = (state_q == ST_IDLE);
  assign res_valid_o = (state_q == ST_RESP);

  assign accept     = req_valid_i & req_ready_o;
  assign res_fire_o = res_valid_o & res_ready_i;

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (accept) begin
          state_d = ST_RESP;
        end
      end
      ST_RESP: begin
        // Back to idle once the response is taken, write-back happens on the same edge
        if (res_fire_o) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Opcode, dirty flag and mask steer the selector
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      op_q    <= OP_LOOKUP;
      dirty_q <= 1'b0;
      mask_q  <= '0;
    end else if (accept) begin
      op_q    <= req_op_i;
      dirty_q <= req_dirty_i;
      mask_q  <= req_way_mask_i;
    end
  end

  // Tag and index only matter while a response is pending
  always_ff @(posedge clk_i) begin
    if (accept) begin
      tag_q   <= req_tag_i;
      index_q <= req_index_i;
    end
  end

  assign op_q_o    = op_q;
  assign tag_q_o   = tag_q;
  assign dirty_q_o = dirty_q;
  assign mask_q_o  = mask_q;

  // Read the enabled ways in the accept cycle, data is back for the respond state
  assign ram_rd_o = {`TS_NUM_WAYS{accept}} & req_way_mask_i;

  // Write into the selected way on the transfer edge
  assign ram_we_o = {`TS_NUM_WAYS{res_fire_o & wr_en_i}} & sel_way_i;

  // Incoming index while idle, held index for the write-back
  assign ram_index_o = req_ready_o ? req_index_i : index_q;

  // The selector has no view of the request tag
  // Every valid line written belongs to the request, so the held tag goes in
  always_comb begin
    ram_wdata_o = wr_line_i;
    if (wr_line_i.valid) begin
      ram_wdata_o.tag = tag_q;
    end
  end

endmodule

// File: hw/tag_store_pkg.sv
// Shared types of the cache tag store; import into every module that carries tags or lines
`include "tag_store_defines.svh"

package tag_store_pkg;

  // Request operation
  typedef enum logic {
    OP_LOOKUP = 1'b0,
    OP_FLUSH  = 1'b1
  } op_e;

  // Controller states, one request in flight
  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_RESP = 1'b1
  } state_e;

  typedef logic [`TS_TAG_W-1:0]    tag_t;
  typedef logic [`TS_INDEX_W-1:0]  index_t;
  typedef logic [`TS_NUM_WAYS-1:0] way_mask_t;
  typedef logic [1:0]              way_idx_t;

  // Content of one way in one set
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } line_t;

endpackage

// File: hw/tag_store_defines.svh
// Size macros of the cache tag store; include in every file that sizes a port or an array
`ifndef TAG_STORE_DEFINES_SVH
`define TAG_STORE_DEFINES_SVH

// Ways per set
// The way number type in the package is two bits wide, so this stays at four
`define TS_NUM_WAYS 4

// Set index width, 16 sets
`define TS_INDEX_W 4

// Stored tag width
`define TS_TAG_W 8

`endif
